//--- logic/display_pkg.sv
`default_nettype none

package display_pkg;

	// Framestore and character row address widths
	localparam int FB_ADR_W = 14;
	localparam int ROW_W = 5;

	// Host horizontal phases
	typedef enum logic [1:0] {
		H_DISPLAY = 2'd0,
		H_FRONT   = 2'd1,
		H_PULSE   = 2'd2,
		H_BACK    = 2'd3
	} h_state_t;

	// Host vertical phases
	typedef enum logic [1:0] {
		V_DISPLAY = 2'd0,
		V_FRONT   = 2'd1,
		V_PULSE   = 2'd2,
		V_BACK    = 2'd3
	} v_state_t;

	// 6845 register indices that are implemented
	typedef enum logic [3:0] {
		CRTC_HORZ_DISP    = 4'd1,
		CRTC_VERT_DISP    = 4'd6,
		CRTC_INTERLACE    = 4'd8,
		CRTC_MAX_SCAN     = 4'd9,
		CRTC_CURSOR_START = 4'd10,
		CRTC_CURSOR_END   = 4'd11,
		CRTC_START_H      = 4'd12,
		CRTC_START_L      = 4'd13,
		CRTC_CURSOR_H     = 4'd14,
		CRTC_CURSOR_L     = 4'd15
	} crtc_reg_e;

	// ULA control byte, segment 0 enable is bit 7
	typedef struct packed {
		logic [0:2] cursor_seg;
		logic       fast_crtc;
		logic [1:0] shift_rate;
		logic       teletext;
		logic       flash_sel;
	} ula_control_t;

	// ULA palette write, logical colour in the top nibble
	typedef struct packed {
		logic [3:0] index;
		logic [3:0] colour;
	} ula_palette_t;

	// Same write byte, meaning chosen by A0
	typedef union packed {
		ula_control_t control;
		ula_palette_t palette;
	} ula_write_t;

endpackage

`default_nettype wire

//--- logic/clock_enables.sv
`timescale 1ns/1ps
`default_nettype none

module clock_enables (
	input wire PIXELCLK,
	input wire nRESET,
	output logic dram_en,
	output logic ram_en,
	output logic crtcf_en,
	output logic crtcs_en,
	output logic proc_en,
	output logic phi2
);

	// Free-running 16-phase sequence
	logic [3:0] phase;

	always_ff @(posedge PIXELCLK) begin
		if (!nRESET) begin
			phase <= 4'd0;
		end else begin
			phase <= phase + 4'd1;
		end
	end

	// Memory rates, every 2nd and 4th clock
	assign dram_en = phase[0];
	assign ram_en = &phase[1:0];

	// Character rates, the fast one lands on a ram_en
	assign crtcf_en = &phase[2:0];
	assign crtcs_en = &phase;

	// Processor cycle, write strobe just before phi2 rises
	assign proc_en = phase == 4'd7;
	assign phi2 = phase[3];

endmodule

`default_nettype wire

//--- logic/vga_timing.sv
`timescale 1ns/1ps
`default_nettype none

module vga_timing #(
	parameter int H_DISPLAY_COUNT = 80,
	parameter int H_FRONT_COUNT = 2,
	parameter int H_PULSE_COUNT = 12,
	parameter int H_BACK_COUNT = 6,
	parameter int V_DISPLAY_COUNT = 480,
	parameter int V_FRONT_COUNT = 10,
	parameter int V_PULSE_COUNT = 2,
	parameter int V_BACK_COUNT = 33
) (
	input wire PIXELCLK,
	input wire nRESET,
	input wire crtc_en,
	input wire half_speed,
	output logic vga_hs,
	output logic vga_vs,
	output logic newline,
	output logic newscreen,
	output logic host_active
);
	import display_pkg::*;

	h_state_t h_state;
	v_state_t v_state;
	logic [7:0] h_count;
	logic [9:0] v_count;
	logic [7:0] h_disp_len;
	logic [7:0] h_front_len;
	logic [7:0] h_pulse_len;
	logic [7:0] h_back_len;

	// Slow characters take twice as long, so half as many of them
	assign h_disp_len = half_speed ? 8'(H_DISPLAY_COUNT / 2) : 8'(H_DISPLAY_COUNT);
	assign h_front_len = half_speed ? 8'(H_FRONT_COUNT / 2) : 8'(H_FRONT_COUNT);
	assign h_pulse_len = half_speed ? 8'(H_PULSE_COUNT / 2) : 8'(H_PULSE_COUNT);
	assign h_back_len = half_speed ? 8'(H_BACK_COUNT / 2) : 8'(H_BACK_COUNT);

	// Each phase counts down to zero then loads the next
	always_ff @(posedge PIXELCLK) begin
		if (!nRESET) begin
			h_state <= H_DISPLAY;
			h_count <= h_disp_len - 8'd1;
		end else if (crtc_en) begin
			if (h_count == 8'd0) begin
				case (h_state)
					H_DISPLAY: begin
						h_state <= H_FRONT;
						h_count <= h_front_len - 8'd1;
					end
					H_FRONT: begin
						h_state <= H_PULSE;
						h_count <= h_pulse_len - 8'd1;
					end
					H_PULSE: begin
						h_state <= H_BACK;
						h_count <= h_back_len - 8'd1;
					end
					default: begin
						h_state <= H_DISPLAY;
						h_count <= h_disp_len - 8'd1;
					end
				endcase
			end else begin
				h_count <= h_count - 8'd1;
			end
		end
	end

	// Last character of the back porch
	assign newline = h_state == H_BACK && h_count == 8'd0;

	always_ff @(posedge PIXELCLK) begin
		if (!nRESET) begin
			v_state <= V_DISPLAY;
			v_count <= 10'(V_DISPLAY_COUNT - 1);
		end else if (crtc_en && newline) begin
			if (v_count == 10'd0) begin
				case (v_state)
					V_DISPLAY: begin
						v_state <= V_FRONT;
						v_count <= 10'(V_FRONT_COUNT - 1);
					end
					V_FRONT: begin
						v_state <= V_PULSE;
						v_count <= 10'(V_PULSE_COUNT - 1);
					end
					V_PULSE: begin
						v_state <= V_BACK;
						v_count <= 10'(V_BACK_COUNT - 1);
					end
					default: begin
						v_state <= V_DISPLAY;
						v_count <= 10'(V_DISPLAY_COUNT - 1);
					end
				endcase
			end else begin
				v_count <= v_count - 10'd1;
			end
		end
	end

	// End of the final back porch line
	assign newscreen = newline && v_state == V_BACK && v_count == 10'd0;

	assign vga_hs = h_state == H_PULSE;
	assign vga_vs = v_state == V_PULSE;
	assign host_active = h_state == H_DISPLAY && v_state == V_DISPLAY;

endmodule

`default_nettype wire

//--- logic/crtc.sv
`timescale 1ns/1ps
`default_nettype none

module crtc (
	input wire PIXELCLK,
	input wire nRESET,
	input wire proc_en,
	input wire crtc_en,
	input wire cs_crtc_n,
	input wire cpu_rnw,
	input wire cpu_a0,
	input wire phi2,
	input wire [7:0] cpu_wdata,
	input wire newline,
	input wire newscreen,
	input wire host_active,
	output logic [7:0] cpu_rdata,
	output logic [display_pkg::FB_ADR_W-1:0] framestore_adr,
	output logic [display_pkg::ROW_W-1:0] row_address,
	output logic disen,
	output logic at_cursor
);
	import display_pkg::*;

	crtc_reg_e reg_sel;
	logic [7:0] horz_display;
	logic [6:0] vert_display;
	logic [1:0] interlace_mode;
	logic [ROW_W-1:0] max_scanline;
	logic [1:0] cursor_blink_mode;
	logic [ROW_W-1:0] cursor_start_row;
	logic [ROW_W-1:0] cursor_end_row;
	logic [FB_ADR_W-1:0] start_adr;
	logic [FB_ADR_W-1:0] cursor_adr;
	logic crtc_write;

	assign crtc_write = proc_en && !cs_crtc_n && !cpu_rnw;

	// A0 low selects the register, high writes it
	always_ff @(posedge PIXELCLK) begin
		if (!nRESET) begin
			reg_sel <= CRTC_HORZ_DISP;
			horz_display <= 8'd0;
			vert_display <= 7'd0;
			interlace_mode <= 2'd0;
			max_scanline <= '0;
			cursor_blink_mode <= 2'd0;
			cursor_start_row <= '0;
			cursor_end_row <= '0;
			start_adr <= '0;
			cursor_adr <= '0;
		end else if (crtc_write) begin
			if (cpu_a0) begin
				case (reg_sel)
					CRTC_HORZ_DISP: horz_display <= cpu_wdata;
					CRTC_VERT_DISP: vert_display <= cpu_wdata[6:0];
					CRTC_INTERLACE: interlace_mode <= cpu_wdata[1:0];
					CRTC_MAX_SCAN: max_scanline <= cpu_wdata[ROW_W-1:0];
					CRTC_CURSOR_START: begin
						cursor_blink_mode <= cpu_wdata[6:5];
						cursor_start_row <= cpu_wdata[ROW_W-1:0];
					end
					CRTC_CURSOR_END: cursor_end_row <= cpu_wdata[ROW_W-1:0];
					CRTC_START_H: start_adr[FB_ADR_W-1:8] <= cpu_wdata[FB_ADR_W-9:0];
					CRTC_START_L: start_adr[7:0] <= cpu_wdata;
					CRTC_CURSOR_H: cursor_adr[FB_ADR_W-1:8] <= cpu_wdata[FB_ADR_W-9:0];
					CRTC_CURSOR_L: cursor_adr[7:0] <= cpu_wdata;
					default: ;
				endcase
			end else begin
				reg_sel <= crtc_reg_e'(cpu_wdata[3:0]);
			end
		end
	end

	// Cursor address is the only readable register
	always_comb begin
		if (!cs_crtc_n && cpu_rnw && phi2) begin
			cpu_rdata = reg_sel[0] ? cursor_adr[7:0] : 8'(cursor_adr[FB_ADR_W-1:8]);
		end else begin
			cpu_rdata = 8'd0;
		end
	end

	logic [7:0] horz_count;
	logic [6:0] vert_count;
	logic h_end;
	logic field;
	logic new_char_row;
	logic [FB_ADR_W-1:0] line_adr;

	// Last scanline of a character row, odd field only when interlaced
	assign new_char_row = row_address == max_scanline && newline &&
		(interlace_mode == 2'b01 ? field : 1'b1);

	// Window must fit inside the host display area
	assign disen = host_active && !h_end && |vert_count;

	always_ff @(posedge PIXELCLK) begin
		if (!nRESET) begin
			horz_count <= 8'd0;
			vert_count <= 7'd0;
			h_end <= 1'b0;
		end else if (crtc_en) begin
			if (newline) begin
				horz_count <= horz_display;
			end else if (|horz_count) begin
				horz_count <= horz_count - 8'd1;
			end
			if (newscreen) begin
				vert_count <= vert_display;
			end else if (new_char_row && |vert_count) begin
				vert_count <= vert_count - 7'd1;
			end
			h_end <= ~|horz_count;
		end
	end

	always_ff @(posedge PIXELCLK) begin
		if (!nRESET) begin
			framestore_adr <= '0;
			line_adr <= '0;
		end else if (crtc_en) begin
			if (newscreen) begin
				framestore_adr <= start_adr;
				line_adr <= start_adr;
			end else if (new_char_row) begin
				framestore_adr <= line_adr + FB_ADR_W'(horz_display);
				line_adr <= line_adr + FB_ADR_W'(horz_display);
			end else if (newline) begin
				framestore_adr <= line_adr;
			end else begin
				framestore_adr <= framestore_adr + FB_ADR_W'(1);
			end
		end
	end

	// Interlace sync shown progressively, each row repeated
	always_ff @(posedge PIXELCLK) begin
		if (!nRESET) begin
			row_address <= '0;
			field <= 1'b0;
		end else if (crtc_en) begin
			if (new_char_row || newscreen) begin
				row_address <= '0;
				field <= 1'b0;
			end else if (newline) begin
				field <= ~field;
				if (interlace_mode != 2'b01 || field) begin
					row_address <= row_address + ROW_W'(1);
				end
			end
		end
	end

	logic [5:0] blink_count;
	logic cursor_on;

	always_ff @(posedge PIXELCLK) begin
		if (!nRESET) begin
			blink_count <= 6'd0;
		end else if (crtc_en && newscreen) begin
			blink_count <= blink_count + 6'd1;
		end
	end

	// Steady, off, then fast and slow blink
	always_comb begin
		case (cursor_blink_mode)
			2'b00: cursor_on = 1'b1;
			2'b01: cursor_on = 1'b0;
			2'b10: cursor_on = blink_count[4];
			default: cursor_on = blink_count[5];
		endcase
	end

	assign at_cursor = framestore_adr == cursor_adr && row_address >= cursor_start_row &&
		row_address <= cursor_end_row && disen && cursor_on;

endmodule

`default_nettype wire

//--- logic/video_ula.sv
`timescale 1ns/1ps
`default_nettype none

module video_ula (
	input wire PIXELCLK,
	input wire nRESET,
	input wire proc_en,
	input wire cs_ula_n,
	input wire cpu_a0,
	input wire [7:0] cpu_wdata,
	input wire dram_en,
	input wire ram_en,
	input wire crtcf_en,
	input wire crtcs_en,
	input wire [7:0] vdata,
	input wire disen,
	input wire at_cursor,
	input wire [display_pkg::ROW_W-1:0] row_address,
	output logic crtc_en,
	output logic half_speed,
	output logic red,
	output logic green,
	output logic blue
);
	import display_pkg::*;

	ula_write_t wr;
	ula_control_t control;
	logic [3:0] palette [16];

	assign wr = cpu_wdata;

	// Write-only part, A0 picks control or palette
	always_ff @(posedge PIXELCLK) begin
		if (!nRESET) begin
			control <= '0;
		end else if (proc_en && !cs_ula_n && !cpu_a0) begin
			control <= wr.control;
		end
	end

	always_ff @(posedge PIXELCLK) begin
		if (proc_en && !cs_ula_n && cpu_a0) begin
			palette[wr.palette.index] <= wr.palette.colour;
		end
	end

	// Fast mode skips the ram_en that is also a crtcf_en
	assign crtc_en = control.fast_crtc ? ram_en && !crtcf_en : crtcs_en;
	assign half_speed = !control.fast_crtc;

	logic shift_en;
	logic [7:0] shifter;

	always_comb begin
		case (control.shift_rate)
			2'b00: shift_en = crtcf_en;
			2'b01: shift_en = ram_en;
			2'b10: shift_en = dram_en;
			default: shift_en = 1'b1;
		endcase
	end

	// Ones shift in behind the byte
	always_ff @(posedge PIXELCLK) begin
		if (crtc_en) begin
			shifter <= vdata;
		end else if (shift_en) begin
			shifter <= {shifter[6:0], 1'b1};
		end
	end

	logic [2:0] cursor_seg;
	logic cursor_draw;

	// Segment 2 covers two characters
	always_ff @(posedge PIXELCLK) begin
		if (!nRESET) begin
			cursor_seg <= 3'b000;
			cursor_draw <= 1'b0;
		end else if (crtc_en) begin
			cursor_seg <= at_cursor ? 3'b001 : {cursor_seg[1:0], 1'b0};
			cursor_draw <= (at_cursor && control.cursor_seg[0]) ||
				(cursor_seg[0] && control.cursor_seg[1]) ||
				(cursor_seg[1] && control.cursor_seg[2]) ||
				(cursor_seg[2] && control.cursor_seg[2]);
		end
	end

	logic [3:0] colour;
	logic invert;
	logic [2:0] pixel;

	assign colour = palette[{shifter[7], shifter[5], shifter[3], shifter[1]}];

	// Flashing entries invert unless flash select is set
	assign invert = !(colour[3] && control.flash_sel);
	assign pixel = (disen && !row_address[3]) ? (invert ? ~colour[2:0] : colour[2:0]) : 3'b000;

	always_comb begin
		if (disen) begin
			{blue, green, red} = cursor_draw ? ~pixel : pixel;
		end else begin
			{blue, green, red} = 3'b000;
		end
	end

endmodule

`default_nettype wire

//--- logic/display_control.sv
`timescale 1ns/1ps
`default_nettype none

module display_control #(
	parameter int H_DISPLAY_COUNT = 80,
	parameter int H_FRONT_COUNT = 2,
	parameter int H_PULSE_COUNT = 12,
	parameter int H_BACK_COUNT = 6,
	parameter int V_DISPLAY_COUNT = 480,
	parameter int V_FRONT_COUNT = 10,
	parameter int V_PULSE_COUNT = 2,
	parameter int V_BACK_COUNT = 33
) (
	input wire PIXELCLK,
	input wire nRESET,
	input wire cs_crtc_n,
	input wire cs_ula_n,
	input wire cpu_rnw,
	input wire cpu_a0,
	input wire [7:0] cpu_wdata,
	input wire [7:0] vdata,
	output logic [7:0] cpu_rdata,
	output logic vga_hs,
	output logic vga_vs,
	output logic red,
	output logic green,
	output logic blue,
	output logic [display_pkg::FB_ADR_W-1:0] framestore_adr,
	output logic [display_pkg::ROW_W-1:0] row_address
);

	logic dram_en;
	logic ram_en;
	logic crtcf_en;
	logic crtcs_en;
	logic proc_en;
	logic phi2;
	logic crtc_en;
	logic half_speed;
	logic newline;
	logic newscreen;
	logic host_active;
	logic disen;
	logic at_cursor;

	clock_enables i_clock_enables (
		.PIXELCLK(PIXELCLK),
		.nRESET(nRESET),
		.dram_en(dram_en),
		.ram_en(ram_en),
		.crtcf_en(crtcf_en),
		.crtcs_en(crtcs_en),
		.proc_en(proc_en),
		.phi2(phi2)
	);

	vga_timing #(
		.H_DISPLAY_COUNT(H_DISPLAY_COUNT),
		.H_FRONT_COUNT(H_FRONT_COUNT),
		.H_PULSE_COUNT(H_PULSE_COUNT),
		.H_BACK_COUNT(H_BACK_COUNT),
		.V_DISPLAY_COUNT(V_DISPLAY_COUNT),
		.V_FRONT_COUNT(V_FRONT_COUNT),
		.V_PULSE_COUNT(V_PULSE_COUNT),
		.V_BACK_COUNT(V_BACK_COUNT)
	) i_vga_timing (
		.PIXELCLK(PIXELCLK),
		.nRESET(nRESET),
		.crtc_en(crtc_en),
		.half_speed(half_speed),
		.vga_hs(vga_hs),
		.vga_vs(vga_vs),
		.newline(newline),
		.newscreen(newscreen),
		.host_active(host_active)
	);

	crtc i_crtc (
		.PIXELCLK(PIXELCLK),
		.nRESET(nRESET),
		.proc_en(proc_en),
		.crtc_en(crtc_en),
		.cs_crtc_n(cs_crtc_n),
		.cpu_rnw(cpu_rnw),
		.cpu_a0(cpu_a0),
		.phi2(phi2),
		.cpu_wdata(cpu_wdata),
		.newline(newline),
		.newscreen(newscreen),
		.host_active(host_active),
		.cpu_rdata(cpu_rdata),
		.framestore_adr(framestore_adr),
		.row_address(row_address),
		.disen(disen),
		.at_cursor(at_cursor)
	);

	video_ula i_video_ula (
		.PIXELCLK(PIXELCLK),
		.nRESET(nRESET),
		.proc_en(proc_en),
		.cs_ula_n(cs_ula_n),
		.cpu_a0(cpu_a0),
		.cpu_wdata(cpu_wdata),
		.dram_en(dram_en),
		.ram_en(ram_en),
		.crtcf_en(crtcf_en),
		.crtcs_en(crtcs_en),
		.vdata(vdata),
		.disen(disen),
		.at_cursor(at_cursor),
		.row_address(row_address),
		.crtc_en(crtc_en),
		.half_speed(half_speed),
		.red(red),
		.green(green),
		.blue(blue)
	);

endmodule

`default_nettype wire

//--- testbench/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
	output logic PIXELCLK,
	output logic nRESET
);

	// 50 MHz pixel clock
	initial begin
		PIXELCLK = 1'b0;
		forever #10 PIXELCLK = ~PIXELCLK;
	end

	// Reset held over the first 16 rising edges
	initial begin
		nRESET = 1'b0;
		repeat (16) @(posedge PIXELCLK);
		nRESET <= 1'b1;
	end

endmodule

`default_nettype wire

//--- testbench/display_control_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module display_control_assertions (
	input wire PIXELCLK,
	input wire nRESET,
	input wire vga_hs,
	input wire vga_vs,
	input wire red,
	input wire green,
	input wire blue,
	input wire disen,
	input wire [display_pkg::ROW_W-1:0] row_address,
	input wire [display_pkg::ROW_W-1:0] max_scanline
);

	// Syncs idle while reset is held
	reset_syncs_low: assert property (@(posedge PIXELCLK)
		!nRESET && !$past(nRESET) |-> !vga_hs && !vga_vs)
		else $error("host sync active during reset");

	row_in_range: assert property (@(posedge PIXELCLK) disable iff (!nRESET)
		disen |-> row_address <= max_scanline)
		else $error("row address beyond max scanline inside the display window");

	// Both syncs high is deep in blanking
	colour_blank_in_sync: assert property (@(posedge PIXELCLK) disable iff (!nRESET)
		vga_hs && vga_vs |-> !red && !green && !blue)
		else $error("colour output active during sync");

endmodule

bind display_control display_control_assertions i_display_control_assertions (
	.PIXELCLK(PIXELCLK),
	.nRESET(nRESET),
	.vga_hs(vga_hs),
	.vga_vs(vga_vs),
	.red(red),
	.green(green),
	.blue(blue),
	.disen(i_crtc.disen),
	.row_address(row_address),
	.max_scanline(i_crtc.max_scanline)
);

`default_nettype wire

//--- testbench/display_control_tb.sv
`timescale 1ns/1ps
`default_nettype none

module display_control_tb;
	import display_pkg::*;

	localparam int H_DISP = 8;
	localparam int H_FRONT = 2;
	localparam int H_PULSE = 2;
	localparam int H_BACK = 4;
	localparam int V_DISP = 20;
	localparam int V_FRONT = 2;
	localparam int V_PULSE = 2;
	localparam int V_BACK = 2;
	localparam int LINE_CLKS = (H_DISP + H_FRONT + H_PULSE + H_BACK) * 8;
	localparam int FRAME_CLKS = (V_DISP + V_FRONT + V_PULSE + V_BACK) * LINE_CLKS;

	// CRTC programming, max scanline reaches row 8 so bit 3 blanking shows
	localparam int HORZ = 6;
	localparam int VERT = 4;
	localparam int MAX_SCAN = 8;
	localparam int CUR_END = 1;
	localparam int START_ADR = 'h0123;
	localparam int CURSOR_ADR = START_ADR + 8;

	wire PIXELCLK;
	wire nRESET;
	logic cs_crtc_n;
	logic cs_ula_n;
	logic cpu_rnw;
	logic cpu_a0;
	logic [7:0] cpu_wdata;
	logic [7:0] vdata;
	wire [7:0] cpu_rdata;
	wire vga_hs;
	wire vga_vs;
	wire red;
	wire green;
	wire blue;
	wire [FB_ADR_W-1:0] framestore_adr;
	wire [ROW_W-1:0] row_address;

	logic [31:0] lfsr;
	logic [3:0] pal_model [16];
	logic [7:0] cur_byte;
	logic [7:0] pend_byte;
	logic flash_sel_set;

	tb_clock i_tb_clock (
		.PIXELCLK(PIXELCLK),
		.nRESET(nRESET)
	);

	display_control #(
		.H_DISPLAY_COUNT(H_DISP),
		.H_FRONT_COUNT(H_FRONT),
		.H_PULSE_COUNT(H_PULSE),
		.H_BACK_COUNT(H_BACK),
		.V_DISPLAY_COUNT(V_DISP),
		.V_FRONT_COUNT(V_FRONT),
		.V_PULSE_COUNT(V_PULSE),
		.V_BACK_COUNT(V_BACK)
	) i_display_control (
		.PIXELCLK(PIXELCLK),
		.nRESET(nRESET),
		.cs_crtc_n(cs_crtc_n),
		.cs_ula_n(cs_ula_n),
		.cpu_rnw(cpu_rnw),
		.cpu_a0(cpu_a0),
		.cpu_wdata(cpu_wdata),
		.vdata(vdata),
		.cpu_rdata(cpu_rdata),
		.vga_hs(vga_hs),
		.vga_vs(vga_vs),
		.red(red),
		.green(green),
		.blue(blue),
		.framestore_adr(framestore_adr),
		.row_address(row_address)
	);

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		lfsr_step = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic random_byte(output logic [7:0] b);
		b = 8'd0;
		for (int i = 0; i < 8; i++) begin
			lfsr = lfsr_step(lfsr);
			b = {b[6:0], lfsr[0]};
		end
	endtask

	task automatic stop_on_failure(input string what);
		$display("%s", what);
		$display("STATUS: FAIL");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic check_value(input string name, input int actual, input int expected);
		assert (actual == expected) else begin
			stop_on_failure($sformatf("mismatch at %0t ns: %s is %0h, expected %0h",
				$time, name, actual, expected));
		end
	endtask

	// Select held for 16 clocks so exactly one proc_en lands inside
	task automatic bus_write(input logic to_crtc, input logic a0, input logic [7:0] data);
		@(posedge PIXELCLK);
		cs_crtc_n <= !to_crtc;
		cs_ula_n <= to_crtc;
		cpu_rnw <= 1'b0;
		cpu_a0 <= a0;
		cpu_wdata <= data;
		repeat (16) @(posedge PIXELCLK);
		cs_crtc_n <= 1'b1;
		cs_ula_n <= 1'b1;
		cpu_rnw <= 1'b1;
	endtask

	task automatic crtc_reg_write(input crtc_reg_e idx, input logic [7:0] data);
		bus_write(1'b1, 1'b0, 8'(idx));
		bus_write(1'b1, 1'b1, data);
	endtask

	// Data only appears while phi2 is high, half of each 16-clock cycle
	task automatic cursor_read(input crtc_reg_e idx, input int expected);
		int seen;
		seen = 0;
		bus_write(1'b1, 1'b0, 8'(idx));
		@(posedge PIXELCLK);
		cs_crtc_n <= 1'b0;
		cpu_rnw <= 1'b1;
		repeat (16) begin
			@(negedge PIXELCLK);
			if (cpu_rdata != 8'd0) begin
				check_value("cpu_rdata", int'(cpu_rdata), expected);
				seen++;
			end
		end
		@(posedge PIXELCLK);
		cs_crtc_n <= 1'b1;
		repeat (16) begin
			@(negedge PIXELCLK);
			check_value("cpu_rdata", int'(cpu_rdata), 0);
		end
		check_value("cpu_rdata valid clocks", seen, 8);
	endtask

	task automatic wait_level(input bit vertical, input logic level, input int limit);
		int n;
		n = 0;
		@(negedge PIXELCLK);
		while ((vertical ? vga_vs : vga_hs) != level) begin
			@(negedge PIXELCLK);
			n++;
			if (n > limit) begin
				stop_on_failure($sformatf("timed out waiting for %s to go %0d",
					vertical ? "vga_vs" : "vga_hs", level));
			end
		end
	endtask

	task automatic measure_sync(input bit vertical, input int limit, output int high,
			output int period);
		wait_level(vertical, 1'b0, limit);
		wait_level(vertical, 1'b1, limit);
		high = 0;
		while ((vertical ? vga_vs : vga_hs) == 1'b1) begin
			@(negedge PIXELCLK);
			high++;
			if (high > limit) begin
				stop_on_failure($sformatf("%s stayed high too long",
					vertical ? "vga_vs" : "vga_hs"));
			end
		end
		period = high;
		while ((vertical ? vga_vs : vga_hs) == 1'b0) begin
			@(negedge PIXELCLK);
			period++;
			if (period > limit) begin
				stop_on_failure($sformatf("%s never rose again",
					vertical ? "vga_vs" : "vga_hs"));
			end
		end
	endtask

	// One frame, clock by clock, from the first display line on
	task automatic check_frame(input int rep);
		int row;
		int base;
		bit win;
		bit cursor_prev;
		logic [7:0] sh;
		logic [3:0] c;
		logic [2:0] pix;
		logic [7:0] b;
		wait_level(1'b1, 1'b1, FRAME_CLKS * 2);
		wait_level(1'b1, 1'b0, FRAME_CLKS * 2);
		repeat (V_BACK * LINE_CLKS) @(negedge PIXELCLK);
		cur_byte = pend_byte;
		for (int l = 0; l < V_DISP; l++) begin
			row = (l / rep) % (MAX_SCAN + 1);
			base = START_ADR + (l / (rep * (MAX_SCAN + 1))) * HORZ;
			for (int k = 0; k < 16; k++) begin
				// Window lags the line start by one character
				win = k >= 1 && k <= HORZ;
				cursor_prev = k >= 2 && k - 1 <= HORZ && base + k - 1 == CURSOR_ADR &&
					row <= CUR_END;
				for (int j = 0; j < 8; j++) begin
					check_value("framestore_adr", int'(framestore_adr), (base + k) & 'h3fff);
					check_value("row_address", int'(row_address), row);
					sh = 8'((int'(cur_byte) << j) | ((1 << j) - 1));
					c = pal_model[{sh[7], sh[5], sh[3], sh[1]}];
					pix = (c[3] && flash_sel_set) ? c[2:0] : ~c[2:0];
					if ((row & 8) != 0) begin
						pix = 3'b000;
					end
					if (cursor_prev) begin
						pix = ~pix;
					end
					check_value("rgb", int'({blue, green, red}), win ? int'(pix) : 0);
					@(posedge PIXELCLK);
					if (j == 3) begin
						random_byte(b);
						vdata <= b;
						pend_byte = b;
					end
					if (j == 7) begin
						cur_byte = pend_byte;
					end
					@(negedge PIXELCLK);
				end
			end
		end
	endtask

	ula_write_t wr;
	int n;
	int high;
	int period;

	initial begin
		cs_crtc_n = 1'b1;
		cs_ula_n = 1'b1;
		cpu_rnw = 1'b1;
		cpu_a0 = 1'b0;
		cpu_wdata = 8'd0;
		vdata = 8'd0;
		lfsr = 32'h0f7eaade;
		cur_byte = 8'd0;
		pend_byte = 8'd0;
		flash_sel_set = 1'b1;
		n = 0;
		while (nRESET !== 1'b1) begin
			@(negedge PIXELCLK);
			n++;
			if (n > 64) begin
				stop_on_failure("reset was never released");
			end
		end

		// Fast CRTC, shift every clock, flash select set, cursor segment 0
		wr = '0;
		wr.control.cursor_seg = 3'b100;
		wr.control.fast_crtc = 1'b1;
		wr.control.shift_rate = 2'b11;
		wr.control.flash_sel = 1'b1;
		bus_write(1'b0, 1'b0, wr);
		for (int i = 0; i < 16; i++) begin
			pal_model[i] = 4'((i * 5 + 3) % 16);
			wr.palette.index = 4'(i);
			wr.palette.colour = pal_model[i];
			bus_write(1'b0, 1'b1, wr);
		end

		crtc_reg_write(CRTC_MAX_SCAN, 8'(MAX_SCAN));
		crtc_reg_write(CRTC_INTERLACE, 8'd0);
		crtc_reg_write(CRTC_CURSOR_START, 8'd0);
		crtc_reg_write(CRTC_CURSOR_END, 8'(CUR_END));
		crtc_reg_write(CRTC_START_H, 8'(START_ADR >> 8));
		crtc_reg_write(CRTC_START_L, 8'(START_ADR));

		// Top two bits of the high byte do not exist
		crtc_reg_write(CRTC_CURSOR_H, 8'hff);
		crtc_reg_write(CRTC_CURSOR_L, 8'ha5);
		cursor_read(CRTC_CURSOR_H, 'h3f);
		cursor_read(CRTC_CURSOR_L, 'ha5);
		crtc_reg_write(CRTC_CURSOR_H, 8'(CURSOR_ADR >> 8));
		crtc_reg_write(CRTC_CURSOR_L, 8'(CURSOR_ADR));
		crtc_reg_write(CRTC_HORZ_DISP, 8'(HORZ));
		crtc_reg_write(CRTC_VERT_DISP, 8'(VERT));

		measure_sync(1'b0, LINE_CLKS * 2, high, period);
		check_value("vga_hs high clocks", high, H_PULSE * 8);
		check_value("vga_hs period", period, LINE_CLKS);
		measure_sync(1'b1, FRAME_CLKS * 2, high, period);
		check_value("vga_vs high clocks", high, V_PULSE * LINE_CLKS);
		check_value("vga_vs period", period, FRAME_CLKS);

		check_frame(1);

		// Flash select cleared, so every palette entry inverts
		wr = '0;
		wr.control.cursor_seg = 3'b100;
		wr.control.fast_crtc = 1'b1;
		wr.control.shift_rate = 2'b11;
		bus_write(1'b0, 1'b0, wr);
		flash_sel_set = 1'b0;
		crtc_reg_write(CRTC_INTERLACE, 8'd1);
		check_frame(2);

		$display("STATUS: PASS");
		$finish;
	end

endmodule

`default_nettype wire

//--- display_control.f
logic/display_pkg.sv
logic/clock_enables.sv
logic/vga_timing.sv
logic/crtc.sv
logic/video_ula.sv
logic/display_control.sv
testbench/tb_clock.sv
testbench/display_control_assertions.sv
testbench/display_control_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build with Verilator, then look for the pass line in the simulation output
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module display_control_tb \
	-f display_control.f -o display_control_sim &&
./obj_dir/display_control_sim | grep "STATUS: PASS" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
